// ==== hw/alpha_cpu_pkg.sv ====
/* Shared widths, idle bus value and decode enums for the two-CPU bus glue.
   Enum values follow the address bit fields they are decoded from. */
`default_nettype none

package alpha_cpu_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W = 16;   // Z80 address bus
    localparam int DATA_W = 8;    // Data byte
    localparam int VA_W   = 12;   // Shared video address bus

    // Floating data bus reads as all ones
    localparam logic [DATA_W-1:0] BUS_IDLE = 8'hFF;

    // ----------------------------------------
    // Memory regions, address bits 15:14
    // ----------------------------------------
    typedef enum logic [1:0] {
        ROM0 = 2'd0,  // 0000-3FFF
        ROM1 = 2'd1,  // 4000-7FFF
        ROM2 = 2'd2,  // 8000-BFFF
        HIGH = 2'd3   // C000-FFFF, I/O and video
    } mem_region_e;

    // CPU A I/O page strobes, address bits 10:8 in C000-C7FF
    typedef enum logic [2:0] {
        COIN    = 3'd0,  // C000 read
        P1      = 3'd1,  // C100 read
        P2      = 3'd2,  // C200 read
        P1_P2   = 3'd3,  // C300 unused
        MCODE   = 3'd4,  // C400 write only
        DIP1    = 3'd5,  // C500 read
        DIP2    = 3'd6,  // C600 read
        MAILBOX = 3'd7   // C700 NMI trigger / ack
    } io_sel_e;

    // Video register strobes, video address bits 10:8
    typedef enum logic [2:0] {
        MSB                   = 3'd0,  // Video attributes
        FSX                   = 3'd1,  // Front scroll X
        FSY                   = 3'd2,  // Front scroll Y
        B1SX                  = 3'd3,  // Back1 scroll X
        B1SY                  = 3'd4,  // Back1 scroll Y
        RSVD5                 = 3'd5,  // No register here
        SIDE_COLOR_BANK       = 3'd6,
        BACK1_TILE_COLOR_BANK = 3'd7
    } vreg_e;

endpackage

`default_nettype wire

// ==== hw/cpu_a_decode.sv ====
/* CPU A memory map and I/O page. a_din is registered, one cycle behind the bus.
   I/O page reads are not qualified by rd_n, the strobe alone selects the byte. */
`timescale 1ns/1ps
`default_nettype none

module cpu_a_decode (
    input  wire                               clk,
    input  wire                               RESETn,
    input  wire  [alpha_cpu_pkg::ADDR_W-1:0]  a_addr,
    input  wire                               a_mreq_n,
    input  wire                               a_rd_n,
    input  wire                               a_wr_n,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  a_rom_data,
    input  wire  [15:0]                       player1,
    input  wire  [15:0]                       player2,
    input  wire  [15:0]                       dsw,
    input  wire                               snd_busy,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  a_vin_q,
    output logic [alpha_cpu_pkg::DATA_W-1:0]  a_din,
    output alpha_cpu_pkg::mem_region_e        a_rom_sel,
    output logic                              ae,
    output logic [7:0]                        io_sel_n,
    output logic                              ctrl_rd,
    output logic                              ctrl_wr
);
    import alpha_cpu_pkg::*;

    logic              io_cs;     // mreq in C000-C7FF
    logic              vid_win;   // Address at or above C800
    io_sel_e           io_idx;
    logic [DATA_W-1:0] coin_byte;

    // Joystick and buttons packed the same way for both players
    function automatic logic [DATA_W-1:0] player_byte(input logic [15:0] p);
        player_byte = {1'b1, p[3], p[2], p[4], p[11], p[10], p[12], p[13]};
    endfunction

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign a_rom_sel = mem_region_e'(a_addr[15:14]);
    assign vid_win   = (a_addr >= 16'hC800);
    assign ae        = !a_mreq_n && vid_win;
    assign io_cs     = !a_mreq_n && (a_addr[15:11] == 5'b11000);
    assign io_idx    = io_sel_e'(a_addr[10:8]);

    // One-of-eight I/O strobe, active low
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            io_sel_n[i] = !(io_cs && (io_idx == io_sel_e'(i)));
        end
    end

    // Mailbox C700, read triggers B NMI, write acks A NMI
    assign ctrl_rd = !io_sel_n[MAILBOX] && !a_rd_n;
    assign ctrl_wr = !io_sel_n[MAILBOX] && !a_wr_n;

    // Unused, sound busy, start2, start1, service, unused, coin
    assign coin_byte = {2'b11, snd_busy, player1[8], player1[1], player1[9],
                        1'b1, player1[0]};

    // ----------------------------------------
    // Read data mux, first match wins
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            a_din <= BUS_IDLE;
        end else if (!a_mreq_n && a_rom_sel != HIGH) begin
            a_din <= a_rom_data;             // ROM0..ROM2
        end else if (io_cs) begin
            case (io_idx)
                COIN:           a_din <= coin_byte;
                P1:             a_din <= player_byte(player1);
                P2:             a_din <= player_byte(player2);
                P1_P2, MAILBOX: a_din <= '1;
                DIP1:           a_din <= dsw[7:0];
                DIP2:           a_din <= dsw[15:8];
                default:        a_din <= BUS_IDLE;  // MCODE is write only
            endcase
        end else if (!a_rd_n && vid_win) begin
            a_din <= a_vin_q;                // Video read-back latch
        end else begin
            a_din <= BUS_IDLE;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpu_b_decode.sv ====
/* CPU B memory map. No I/O page, C000-C7FF is the mailbox only.
   b_din is registered, one cycle behind the bus. */
`timescale 1ns/1ps
`default_nettype none

module cpu_b_decode (
    input  wire                               clk,
    input  wire                               RESETn,
    input  wire  [alpha_cpu_pkg::ADDR_W-1:0]  b_addr,
    input  wire                               b_mreq_n,
    input  wire                               b_rd_n,
    input  wire                               b_wr_n,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  b_rom_data,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  b_vin_q,
    output logic [alpha_cpu_pkg::DATA_W-1:0]  b_din,
    output alpha_cpu_pkg::mem_region_e        b_rom_sel,
    output logic                              be,
    output logic                              ctrl_rd,
    output logic                              ctrl_wr
);
    import alpha_cpu_pkg::*;

    logic mbox_cs;   // mreq in C000-C7FF
    logic vid_win;

    assign b_rom_sel = mem_region_e'(b_addr[15:14]);
    assign vid_win   = (b_addr >= 16'hC800);
    assign be        = !b_mreq_n && vid_win;
    assign mbox_cs   = !b_mreq_n && (b_addr[15:11] == 5'b11000);

    // Read triggers A NMI, write acks B NMI
    assign ctrl_rd = mbox_cs && !b_rd_n;
    assign ctrl_wr = mbox_cs && !b_wr_n;

    // Read data mux
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            b_din <= BUS_IDLE;
        end else if (!b_mreq_n && b_rom_sel != HIGH) begin
            b_din <= b_rom_data;
        end else if (ctrl_rd) begin
            b_din <= '1;          // Mailbox reads as ones
        end else if (!b_rd_n && vid_win) begin
            b_din <= b_vin_q;
        end else begin
            b_din <= BUS_IDLE;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpu_irq_ctrl.sv ====
/* VBL interrupts and cross-CPU NMI mailbox. All outputs registered, active low.
   A clear (iorq or mailbox write) wins over a set in the same cycle. */
`timescale 1ns/1ps
`default_nettype none

module cpu_irq_ctrl (
    input  wire  clk,
    input  wire  RESETn,
    input  wire  vbl,
    input  wire  a_iorq_n,
    input  wire  b_iorq_n,
    input  wire  a_ctrl_rd,
    input  wire  a_ctrl_wr,
    input  wire  b_ctrl_rd,
    input  wire  b_ctrl_wr,
    output logic a_int_n,
    output logic b_int_n,
    output logic a_nmi_n,
    output logic b_nmi_n
);
    logic vbl_q;
    logic a_rd_q;
    logic b_rd_q;
    logic vbl_rise;
    logic a_rd_end;   // CPU A mailbox read just finished
    logic b_rd_end;

    // Edge detect against last cycle's copy
    assign vbl_rise = vbl && !vbl_q;
    assign a_rd_end = a_rd_q && !a_ctrl_rd;
    assign b_rd_end = b_rd_q && !b_ctrl_rd;

    always_ff @(posedge clk) begin
        if (!RESETn) begin
            vbl_q   <= 1'b0;
            a_rd_q  <= 1'b0;
            b_rd_q  <= 1'b0;
            a_int_n <= 1'b1;
            b_int_n <= 1'b1;
            a_nmi_n <= 1'b1;
            b_nmi_n <= 1'b1;
        end else begin
            vbl_q  <= vbl;
            a_rd_q <= a_ctrl_rd;
            b_rd_q <= b_ctrl_rd;

            // ----------------------------------------
            // VBL, cleared by each CPU's int acknowledge
            if (!a_iorq_n)     a_int_n <= 1'b1;
            else if (vbl_rise) a_int_n <= 1'b0;

            if (!b_iorq_n)     b_int_n <= 1'b1;
            else if (vbl_rise) b_int_n <= 1'b0;

            // Mailbox, A reads C700 to kick B, B writes C000 to ack
            if (b_ctrl_wr)     b_nmi_n <= 1'b1;
            else if (a_rd_end) b_nmi_n <= 1'b0;

            // Mirror, B reads C000 to kick A, A writes C700 to ack
            if (a_ctrl_wr)     a_nmi_n <= 1'b1;
            else if (b_rd_end) a_nmi_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/video_bus_port.sv ====
/* Shared video bus. a_b picks the owner for address and chip selects;
   write data follows wba/wbb independently of a_b. Read-back latches load while rl* high. */
`timescale 1ns/1ps
`default_nettype none

module video_bus_port (
    input  wire                               clk,
    input  wire                               RESETn,
    input  wire                               a_b,
    input  wire  [alpha_cpu_pkg::ADDR_W-1:0]  a_addr,
    input  wire  [alpha_cpu_pkg::ADDR_W-1:0]  b_addr,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  a_dout,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  b_dout,
    input  wire                               a_mreq_n,
    input  wire                               b_mreq_n,
    input  wire                               a_rd_n,
    input  wire                               b_rd_n,
    input  wire                               wba,
    input  wire                               wbb,
    input  wire                               rla,
    input  wire                               rlb,
    input  wire                               vdg,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  v_in,
    output logic [alpha_cpu_pkg::VA_W-1:0]    va,
    output logic [alpha_cpu_pkg::DATA_W-1:0]  v_out,
    output logic [alpha_cpu_pkg::DATA_W-1:0]  a_vin_q,
    output logic [alpha_cpu_pkg::DATA_W-1:0]  b_vin_q,
    output logic                              front_cs_n,
    output logic                              side_cs_n,
    output logic                              back1_cs_n,
    output logic                              vrd_n,
    output logic                              disc,
    output logic [7:0]                        vreg_sel_n
);
    import alpha_cpu_pkg::*;

    logic [ADDR_W-1:0] own_addr;   // Address of current owner
    logic              own_mreq_n;
    logic              own_rd_n;
    logic [4:0]        blk;        // 2K block, address bits 15:11
    vreg_e             vreg_idx;

    // ----------------------------------------
    // Owner mux, high selects CPU B
    // ----------------------------------------
    assign own_addr   = a_b ? b_addr   : a_addr;
    assign own_mreq_n = a_b ? b_mreq_n : a_mreq_n;
    assign own_rd_n   = a_b ? b_rd_n   : a_rd_n;
    assign va         = own_addr[VA_W-1:0];
    assign blk        = own_addr[15:11];

    // Write data, A has priority
    assign v_out = !wba ? a_dout : (!wbb ? b_dout : BUS_IDLE);

    // Chip selects, active low
    assign disc       = !(!own_mreq_n && blk == 5'b11001);              // C800-CFFF
    assign front_cs_n = !(!own_mreq_n && blk == 5'b11010);              // D000-D7FF
    assign back1_cs_n = !(!own_mreq_n && blk >= 5'b11011 && blk <= 5'b11110);
    assign side_cs_n  = !(!own_mreq_n && blk == 5'b11111);              // F800-FFFF
    assign vrd_n      = !(!own_mreq_n && !own_rd_n && blk >= 5'b11001);

    // Register strobes, enabled by disc and vdg both low
    assign vreg_idx = vreg_e'(va[10:8]);
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            vreg_sel_n[i] = !(!disc && !vdg && (vreg_idx == vreg_e'(i)));
        end
    end

    // ----------------------------------------
    // Read-back latches, clocked transparent
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!RESETn) begin
            a_vin_q <= '0;
            b_vin_q <= '0;
        end else begin
            if (rla) a_vin_q <= v_in;
            if (rlb) b_vin_q <= v_in;
        end
    end

endmodule

`default_nettype wire

// ==== hw/alpha_cpu_glue.sv ====
/* Bus glue top for the two-CPU main board. CPU buses and ROM data come in as ports;
   all strobes are active low where the name ends in _n. */
`timescale 1ns/1ps
`default_nettype none

module alpha_cpu_glue (
    input  wire                               clk,
    input  wire                               RESETn,
    // CPU A bus
    input  wire  [alpha_cpu_pkg::ADDR_W-1:0]  a_addr,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  a_dout,
    input  wire                               a_mreq_n,
    input  wire                               a_iorq_n,
    input  wire                               a_rd_n,
    input  wire                               a_wr_n,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  a_rom_data,
    // CPU B bus
    input  wire  [alpha_cpu_pkg::ADDR_W-1:0]  b_addr,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  b_dout,
    input  wire                               b_mreq_n,
    input  wire                               b_iorq_n,
    input  wire                               b_rd_n,
    input  wire                               b_wr_n,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  b_rom_data,
    // Inputs and timing
    input  wire  [15:0]                       player1,
    input  wire  [15:0]                       player2,
    input  wire  [15:0]                       dsw,
    input  wire                               snd_busy,
    input  wire                               vbl,
    // Video bus control
    input  wire                               a_b,
    input  wire                               wba,
    input  wire                               wbb,
    input  wire                               rla,
    input  wire                               rlb,
    input  wire                               vdg,
    input  wire  [alpha_cpu_pkg::DATA_W-1:0]  v_in,
    // Outputs
    output logic [alpha_cpu_pkg::DATA_W-1:0]  a_din,
    output logic [alpha_cpu_pkg::DATA_W-1:0]  b_din,
    output alpha_cpu_pkg::mem_region_e        a_rom_sel,
    output alpha_cpu_pkg::mem_region_e        b_rom_sel,
    output logic                              ae,
    output logic                              be,
    output logic [7:0]                        io_sel_n,
    output logic                              a_int_n,
    output logic                              b_int_n,
    output logic                              a_nmi_n,
    output logic                              b_nmi_n,
    output logic [alpha_cpu_pkg::VA_W-1:0]    va,
    output logic [alpha_cpu_pkg::DATA_W-1:0]  v_out,
    output logic                              front_cs_n,
    output logic                              side_cs_n,
    output logic                              back1_cs_n,
    output logic                              vrd_n,
    output logic                              disc,
    output logic [7:0]                        vreg_sel_n
);
    import alpha_cpu_pkg::*;

    logic              a_ctrl_rd;   // Mailbox strobes
    logic              a_ctrl_wr;
    logic              b_ctrl_rd;
    logic              b_ctrl_wr;
    logic [DATA_W-1:0] a_vin_q;     // Video read-back per CPU
    logic [DATA_W-1:0] b_vin_q;

    // ----------------------------------------
    cpu_a_decode u_cpu_a (
        .clk(clk), .RESETn(RESETn),
        .a_addr(a_addr), .a_mreq_n(a_mreq_n), .a_rd_n(a_rd_n), .a_wr_n(a_wr_n),
        .a_rom_data(a_rom_data), .player1(player1), .player2(player2), .dsw(dsw),
        .snd_busy(snd_busy), .a_vin_q(a_vin_q),
        .a_din(a_din), .a_rom_sel(a_rom_sel), .ae(ae), .io_sel_n(io_sel_n),
        .ctrl_rd(a_ctrl_rd), .ctrl_wr(a_ctrl_wr)
    );

    cpu_b_decode u_cpu_b (
        .clk(clk), .RESETn(RESETn),
        .b_addr(b_addr), .b_mreq_n(b_mreq_n), .b_rd_n(b_rd_n), .b_wr_n(b_wr_n),
        .b_rom_data(b_rom_data), .b_vin_q(b_vin_q),
        .b_din(b_din), .b_rom_sel(b_rom_sel), .be(be),
        .ctrl_rd(b_ctrl_rd), .ctrl_wr(b_ctrl_wr)
    );

    cpu_irq_ctrl u_irq (
        .clk(clk), .RESETn(RESETn), .vbl(vbl),
        .a_iorq_n(a_iorq_n), .b_iorq_n(b_iorq_n),
        .a_ctrl_rd(a_ctrl_rd), .a_ctrl_wr(a_ctrl_wr),
        .b_ctrl_rd(b_ctrl_rd), .b_ctrl_wr(b_ctrl_wr),
        .a_int_n(a_int_n), .b_int_n(b_int_n), .a_nmi_n(a_nmi_n), .b_nmi_n(b_nmi_n)
    );

    video_bus_port u_vid (
        .clk(clk), .RESETn(RESETn), .a_b(a_b),
        .a_addr(a_addr), .b_addr(b_addr), .a_dout(a_dout), .b_dout(b_dout),
        .a_mreq_n(a_mreq_n), .b_mreq_n(b_mreq_n), .a_rd_n(a_rd_n), .b_rd_n(b_rd_n),
        .wba(wba), .wbb(wbb), .rla(rla), .rlb(rlb), .vdg(vdg), .v_in(v_in),
        .va(va), .v_out(v_out), .a_vin_q(a_vin_q), .b_vin_q(b_vin_q),
        .front_cs_n(front_cs_n), .side_cs_n(side_cs_n), .back1_cs_n(back1_cs_n),
        .vrd_n(vrd_n), .disc(disc), .vreg_sel_n(vreg_sel_n)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
/* 10 ns clock, active low reset held for 8 cycles.
   Reset is released on a falling edge. */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic RESETn
);
    initial clk = 1'b0;
    always #5 clk = ~clk;   // 100 MHz

    initial begin
        RESETn = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        RESETn = 1'b1;
    end
endmodule

`default_nettype wire

// ==== tb/alpha_cpu_glue_chk.sv ====
/* Concurrent checks on the glue top level ports of every instance.
   Disabled while reset is low. */
`timescale 1ns/1ps
`default_nettype none

module alpha_cpu_glue_chk (
    input wire                               clk,
    input wire                               RESETn,
    input wire [alpha_cpu_pkg::ADDR_W-1:0]   a_addr,
    input wire [alpha_cpu_pkg::ADDR_W-1:0]   b_addr,
    input wire                               a_mreq_n,
    input wire [alpha_cpu_pkg::DATA_W-1:0]   a_rom_data,
    input wire [alpha_cpu_pkg::DATA_W-1:0]   a_din,
    input alpha_cpu_pkg::mem_region_e        a_rom_sel,
    input alpha_cpu_pkg::mem_region_e        b_rom_sel,
    input wire                               ae,
    input wire                               vbl,
    input wire                               a_iorq_n,
    input wire                               a_int_n,
    input wire                               disc,
    input wire                               vdg,
    input wire [7:0]                         vreg_sel_n
);
    int fail_count = 0;   // Failed assertions so far

    // ----------------------------------------
    // Memory map
    a_region: assert property (@(posedge clk) disable iff (!RESETn)
        a_rom_sel == a_addr[15:14])
        else begin
            $error("CPU A region decode wrong");
            fail_count++;
        end
    b_region: assert property (@(posedge clk) disable iff (!RESETn)
        b_rom_sel == b_addr[15:14])
        else begin
            $error("CPU B region decode wrong");
            fail_count++;
        end
    a_window: assert property (@(posedge clk) disable iff (!RESETn)
        ae == (!a_mreq_n && a_addr >= 16'hC800))
        else begin
            $error("ae decode wrong");
            fail_count++;
        end

    // ROM byte lands in a_din one clock later
    a_rom_path: assert property (@(posedge clk) disable iff (!RESETn)
        (!a_mreq_n && a_addr[15:14] != 2'b11) |=> a_din == $past(a_rom_data))
        else begin
            $error("a_din missed ROM data");
            fail_count++;
        end

    // ----------------------------------------
    // Interrupts and video strobes
    vbl_int: assert property (@(posedge clk) disable iff (!RESETn)
        ($rose(vbl) && a_iorq_n) |=> !a_int_n)
        else begin
            $error("VBL did not raise a_int_n");
            fail_count++;
        end
    int_ack: assert property (@(posedge clk) disable iff (!RESETn)
        !a_iorq_n |=> a_int_n)
        else begin
            $error("iorq did not clear a_int_n");
            fail_count++;
        end
    vreg_idle: assert property (@(posedge clk) disable iff (!RESETn)
        (disc || vdg) |-> vreg_sel_n == 8'hFF)
        else begin
            $error("vreg strobe without enable");
            fail_count++;
        end
endmodule

bind alpha_cpu_glue alpha_cpu_glue_chk chk0 (.*);

`default_nettype wire

// ==== tb/alpha_cpu_glue_tb.sv ====
/* Directed and LFSR driven tests of the bus glue. Inputs change on falling edges.
   Combinational outputs are checked 1 ns later and registered ones after the next rise. */
`timescale 1ns/1ps
`default_nettype none

module alpha_cpu_glue_tb;
    localparam int MAP_N = 32;   // Random memory map trials
    localparam int VID_N = 32;   // Random video bus trials
    localparam int LIMIT = 2 * (10 + MAP_N + 10 + 24 + 8 + VID_N + 8);

    logic        clk, RESETn;
    logic [15:0] a_addr, b_addr, player1, player2, dsw;
    logic [7:0]  a_dout, b_dout, a_rom_data, b_rom_data, v_in;
    logic        a_mreq_n, a_iorq_n, a_rd_n, a_wr_n, b_mreq_n, b_iorq_n, b_rd_n, b_wr_n;
    logic        snd_busy, vbl, a_b, wba, wbb, rla, rlb, vdg;
    wire  [7:0]  a_din, b_din, io_sel_n, v_out, vreg_sel_n;
    wire  [11:0] va;
    alpha_cpu_pkg::mem_region_e a_rom_sel, b_rom_sel;
    wire         ae, be, a_int_n, b_int_n, a_nmi_n, b_nmi_n;
    wire         front_cs_n, side_cs_n, back1_cs_n, vrd_n, disc;

    logic [15:0] lfsr = 16'd16592;
    int          errors = 0;
    int          err_mark = 0;
    int          asrt_mark = 0;   // Assertion failures already counted
    int          tests = 0;
    int          failed = 0;
    int          cycles = 0;

    tb_clkgen clkgen0 (.clk(clk), .RESETn(RESETn));

    alpha_cpu_glue dut0 (.*);

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: no result after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic rnd(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // Galois step
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        errors += dut0.chk0.fail_count - asrt_mark;   // Bound assertion failures
        asrt_mark = dut0.chk0.fail_count;
        tests++;
        if (errors != err_mark) failed++;
        $display("test %-10s %s (%0d errors)", name, (errors == err_mark) ? "pass" : "fail",
                 errors - err_mark);
        err_mark = errors;
    endtask

    task automatic tick;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic bus_idle;
        a_mreq_n = 1'b1;
        a_iorq_n = 1'b1;
        a_rd_n = 1'b1;
        a_wr_n = 1'b1;
        b_mreq_n = 1'b1;
        b_iorq_n = 1'b1;
        b_rd_n = 1'b1;
        b_wr_n = 1'b1;
        wba = 1'b1;
        wbb = 1'b1;
        rla = 1'b0;
        rlb = 1'b0;
        vdg = 1'b1;
    endtask

    // Player byte layout from the I/O page rules
    function automatic logic [7:0] pl_byte(input logic [15:0] p);
        return {1'b1, p[3], p[2], p[4], p[11], p[10], p[12], p[13]};
    endfunction

    function automatic logic [7:0] io_byte(input int idx);
        case (idx)
            0: return {2'b11, snd_busy, player1[8], player1[1], player1[9], 1'b1, player1[0]};
            1: return pl_byte(player1);
            2: return pl_byte(player2);
            5: return dsw[7:0];
            default: return dsw[15:8];
        endcase
    endfunction

    // Active low one-of-eight pattern
    function automatic logic [7:0] strobe_low(input int idx);
        logic [7:0] v;
        v = 8'hFF;
        v[idx] = 1'b0;
        return v;
    endfunction

    // Write data source picked by the two write enables
    function automatic logic [7:0] wr_data();
        if (!wba) return a_dout;
        if (!wbb) return b_dout;
        return 8'hFF;
    endfunction

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [15:0] r, own;
        logic        own_rd, e_disc;
        int          idx;

        bus_idle();
        a_addr = '0;
        b_addr = '0;
        a_dout = '0;
        b_dout = '0;
        a_rom_data = '0;
        b_rom_data = '0;
        v_in = '0;
        player1 = '0;
        player2 = '0;
        dsw = '0;
        snd_busy = 1'b0;
        vbl = 1'b0;
        a_b = 1'b0;
        wait (RESETn);
        tick();

        // Reset state
        check("a_int_n", 16'(a_int_n), 16'd1);
        check("b_int_n", 16'(b_int_n), 16'd1);
        check("a_nmi_n", 16'(a_nmi_n), 16'd1);
        check("b_nmi_n", 16'(b_nmi_n), 16'd1);
        check("a_din", 16'(a_din), 16'hFF);
        check("b_din", 16'(b_din), 16'hFF);
        check("io_sel_n", 16'(io_sel_n), 16'hFF);
        check("vreg_sel_n", 16'(vreg_sel_n), 16'hFF);
        check("chip selects", 16'({front_cs_n, side_cs_n, back1_cs_n, disc}), 16'hF);
        end_test("reset");

        // Memory map. mreq alone keeps the mailbox quiet
        for (int i = 0; i < MAP_N; i++) begin
            rnd(16, a_addr);
            rnd(16, b_addr);
            rnd(16, r);
            a_rom_data = r[7:0];
            b_rom_data = r[15:8];
            a_mreq_n = 1'b0;
            b_mreq_n = 1'b0;
            #1;
            check("a_rom_sel", 16'(a_rom_sel), 16'(a_addr[15:14]));
            check("b_rom_sel", 16'(b_rom_sel), 16'(b_addr[15:14]));
            check("ae", 16'(ae), 16'(a_addr >= 16'hC800));
            check("be", 16'(be), 16'(b_addr >= 16'hC800));
            tick();
            if (a_addr[15:14] != 2'b11) check("a_din", 16'(a_din), 16'(r[7:0]));
            if (b_addr[15:14] != 2'b11) check("b_din", 16'(b_din), 16'(r[15:8]));
        end
        bus_idle();
        end_test("mem_map");

        // CPU A I/O page reads
        for (int k = 0; k < 5; k++) begin
            idx = (k < 3) ? k : k + 2;   // COIN, P1, P2, DIP1, DIP2
            rnd(16, player1);
            rnd(16, player2);
            rnd(16, dsw);
            rnd(1, r);
            snd_busy = r[0];
            rnd(8, r);
            a_addr = {5'b11000, 3'(idx), r[7:0]};
            a_mreq_n = 1'b0;
            a_rd_n = 1'b0;
            #1;
            check("io_sel_n", 16'(io_sel_n), 16'(strobe_low(idx)));
            tick();
            check("a_din", 16'(a_din), 16'(io_byte(idx)));
        end
        bus_idle();
        tick();
        end_test("io_page");

        // A kicks B and B acks
        a_addr = 16'hC700;
        a_mreq_n = 1'b0;
        a_rd_n = 1'b0;
        tick();
        tick();
        check("b_nmi_n", 16'(b_nmi_n), 16'd1);   // Not until the read ends
        bus_idle();
        tick();
        check("b_nmi_n", 16'(b_nmi_n), 16'd0);
        b_addr = 16'hC000;
        b_mreq_n = 1'b0;
        b_wr_n = 1'b0;
        tick();
        check("b_nmi_n", 16'(b_nmi_n), 16'd1);
        bus_idle();
        // B kicks A and A acks
        b_addr = 16'hC000;
        b_mreq_n = 1'b0;
        b_rd_n = 1'b0;
        tick();
        check("a_nmi_n", 16'(a_nmi_n), 16'd1);
        bus_idle();
        tick();
        check("a_nmi_n", 16'(a_nmi_n), 16'd0);
        a_addr = 16'hC700;
        a_mreq_n = 1'b0;
        a_wr_n = 1'b0;
        tick();
        check("a_nmi_n", 16'(a_nmi_n), 16'd1);
        bus_idle();
        // Ack in the same cycle as the trigger
        a_addr = 16'hC700;
        a_mreq_n = 1'b0;
        a_rd_n = 1'b0;
        tick();
        bus_idle();
        b_addr = 16'hC000;
        b_mreq_n = 1'b0;
        b_wr_n = 1'b0;
        tick();
        check("b_nmi_n", 16'(b_nmi_n), 16'd1);
        bus_idle();
        tick();
        check("b_nmi_n", 16'(b_nmi_n), 16'd1);
        end_test("mailbox");

        // VBL interrupts
        vbl = 1'b1;
        tick();
        check("a_int_n", 16'(a_int_n), 16'd0);
        check("b_int_n", 16'(b_int_n), 16'd0);
        a_iorq_n = 1'b0;
        tick();
        check("a_int_n", 16'(a_int_n), 16'd1);
        check("b_int_n", 16'(b_int_n), 16'd0);
        a_iorq_n = 1'b1;
        b_iorq_n = 1'b0;
        tick();
        check("b_int_n", 16'(b_int_n), 16'd1);
        b_iorq_n = 1'b1;
        vbl = 1'b0;
        tick();
        end_test("vbl");

        // Shared video bus with addresses at or above C800
        for (int i = 0; i < VID_N; i++) begin
            rnd(16, r);
            a_addr = {5'd25 + 5'(r[15:0] % 7), r[10:0]};
            rnd(16, r);
            b_addr = {5'd25 + 5'(r[15:0] % 7), r[10:0]};
            rnd(16, r);
            a_dout = r[7:0];
            b_dout = r[15:8];
            rnd(8, r);
            a_b = r[0];
            wba = r[1];
            wbb = r[2];
            vdg = r[3];
            a_rd_n = r[4];
            b_rd_n = r[5];
            a_mreq_n = 1'b0;
            b_mreq_n = 1'b0;
            own    = a_b ? b_addr : a_addr;
            own_rd = a_b ? b_rd_n : a_rd_n;
            e_disc = !(own >= 16'hC800 && own <= 16'hCFFF);
            #1;
            check("va", 16'(va), 16'(own[11:0]));
            check("v_out", 16'(v_out), 16'(wr_data()));
            check("disc", 16'(disc), 16'(e_disc));
            check("front_cs_n", 16'(front_cs_n), 16'(!(own >= 16'hD000 && own <= 16'hD7FF)));
            check("back1_cs_n", 16'(back1_cs_n), 16'(!(own >= 16'hD800 && own <= 16'hF7FF)));
            check("side_cs_n", 16'(side_cs_n), 16'(!(own >= 16'hF800)));
            check("vrd_n", 16'(vrd_n), 16'(own_rd));
            check("vreg_sel_n", 16'(vreg_sel_n),
                  16'((!e_disc && !vdg) ? strobe_low(int'(own[10:8])) : 8'hFF));
            tick();
        end
        bus_idle();
        // Read-back latches
        rnd(16, r);
        v_in = r[7:0];
        rla = 1'b1;
        tick();
        rla = 1'b0;
        v_in = r[15:8];
        rlb = 1'b1;
        tick();
        rlb = 1'b0;
        v_in = 8'h00;
        a_addr = 16'hD123;
        a_mreq_n = 1'b0;
        a_rd_n = 1'b0;
        b_addr = 16'hF456;
        b_mreq_n = 1'b0;
        b_rd_n = 1'b0;
        tick();
        check("a_din", 16'(a_din), 16'(r[7:0]));
        check("b_din", 16'(b_din), 16'(r[15:8]));
        bus_idle();
        end_test("video_bus");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== alpha_cpu_glue.f ====
hw/alpha_cpu_pkg.sv
hw/cpu_a_decode.sv
hw/cpu_b_decode.sv
hw/cpu_irq_ctrl.sv
hw/video_bus_port.sv
hw/alpha_cpu_glue.sv
tb/tb_clkgen.sv
tb/alpha_cpu_glue_chk.sv
tb/alpha_cpu_glue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alpha_cpu_glue_tb
FLIST     ?= alpha_cpu_glue.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
